/* logic/tapePkg.sv */
// Magnetic tape formatter definitions
// Register map, function codes, TC fields and status/error bit positions
// for the Massbus formatter front end

package tapePkg;

   typedef logic [4:0]  regAddrT;                  // Massbus register select
   typedef logic [4:0]  funCodeT;                  // CS1 function field
   typedef logic [15:0] regWordT;                  // Register data word

   ////////////////////////////////////////
   // Register addresses (octal)
   localparam regAddrT regCs1 = 5'o00;             // Control/status
   localparam regAddrT regDs  = 5'o01;             // Drive status
   localparam regAddrT regEr  = 5'o02;             // Error
   localparam regAddrT regMr  = 5'o03;             // Maintenance
   localparam regAddrT regAs  = 5'o04;             // Attention summary
   localparam regAddrT regFc  = 5'o05;             // Frame count
   localparam regAddrT regDt  = 5'o06;             // Drive type
   localparam regAddrT regCc  = 5'o07;             // Check character
   localparam regAddrT regSn  = 5'o10;             // Serial number
   localparam regAddrT regTc  = 5'o11;             // Tape control, last legal

   ////////////////////////////////////////
   // Function codes
   localparam funCodeT funDrvClr   = 5'o04;
   localparam funCodeT funPreset   = 5'o10;        // Read-in preset
   localparam funCodeT funErase    = 5'o12;
   localparam funCodeT funWrTm     = 5'o13;        // Write tape mark
   localparam funCodeT funSpcFwd   = 5'o14;
   localparam funCodeT funSpcRev   = 5'o15;
   localparam funCodeT funWrChkFwd = 5'o24;
   localparam funCodeT funWrChkRev = 5'o27;
   localparam funCodeT funWrFwd    = 5'o30;
   localparam funCodeT funRdFwd    = 5'o34;
   localparam funCodeT funRdRev    = 5'o37;

   // One bit per code
   // Octal 2 5 6 7 11 16 17 20-23 25 26 31-33 35 36 are illegal
   localparam logic [31:0] funIllegal = 32'h6E6F_C2E4;

   ////////////////////////////////////////
   // Tape control fields
   localparam int tcSsLsb  = 0;                    // Slave select, 3 bits
   localparam int tcFmtLsb = 4;                    // Format, 4 bits
   localparam int tcDenLsb = 8;                    // Density, 3 bits

   localparam logic [2:0]  den1600   = 3'd4;       // PE, rest is NRZI
   localparam logic [15:0] fmtLegal  = 16'h5009;   // Formats 0, 3, 12, 14
   localparam regWordT     nrziMinFc = 16'o177763; // Minus 13 frames

   // Error register bits
   localparam int erIlf  = 0;
   localparam int erIlr  = 1;
   localparam int erRmr  = 2;
   localparam int erCpar = 3;
   localparam int erFmte = 4;
   localparam int erNef  = 6;
   localparam int erUns  = 14;

   // Drive status bits
   localparam int dsAta = 15;
   localparam int dsErr = 14;
   localparam int dsPip = 13;
   localparam int dsMol = 12;
   localparam int dsWrl = 11;
   localparam int dsDpr = 8;
   localparam int dsDry = 7;
   localparam int dsBot = 1;

endpackage

/* logic/errorReg.sv */
// Formatter error register
// Sticky error bits set by the register and GO checks, cleared by
// reset or drive clear

module errorReg
(
   input  logic             clk,
   input  logic             rst,
   input  logic             drvClr,
   input  logic             setIlf,                // Illegal function
   input  logic             setIlr,                // Illegal register
   input  logic             setRmr,                // Modify refused
   input  logic             setCpar,               // Control bus parity
   input  logic             setFmte,               // Format error
   input  logic             setNef,                // Non-executable
   input  logic             setUns,                // Unsafe
   output tapePkg::regWordT errWord
);
   import tapePkg::*;

   regWordT setBits;

   always_comb
   begin
      setBits         = '0;
      setBits[erIlf]  = setIlf;
      setBits[erIlr]  = setIlr;
      setBits[erRmr]  = setRmr;
      setBits[erCpar] = setCpar;
      setBits[erFmte] = setFmte;
      setBits[erNef]  = setNef;
      setBits[erUns]  = setUns;
   end

   // A set in the same cycle survives drive clear
   always_ff @(posedge clk)
   begin
      if (rst)
         errWord <= '0;
      else
         errWord <= (drvClr ? '0 : errWord) | setBits;
   end

endmodule

/* logic/regDecode.sv */
// Massbus register decode
// Write strobes, refusal and illegal-register errors, maintenance
// register storage and the combinational read-back multiplexer

module regDecode
#(
   parameter logic [2:0]  unitNum   = 3'd0,
   parameter logic [15:0] driveType = 16'o142054,
   parameter logic [15:0] serialNum = 16'o000017,
   parameter logic [2:0]  slaveAddr = 3'd0
)
(
   input  logic             clk,
   input  logic             rst,
   input  logic [2:0]       unit,
   input  tapePkg::regAddrT regSel,
   input  logic             read,
   input  logic             write,
   input  logic             pat,
   input  tapePkg::regWordT dataIn,
   input  logic             dryState,
   input  tapePkg::regWordT statusWord,
   input  tapePkg::regWordT errWord,
   input  tapePkg::regWordT fcWord,
   input  tapePkg::regWordT tcWord,
   output logic             wrFc,
   output logic             wrTc,
   output logic             wrAs,                  // AS write hitting our bit
   output logic             setIlr,
   output logic             setRmr,
   output logic             setCpar,
   output tapePkg::regWordT regDat,
   output logic             regAck
);
   import tapePkg::*;

   localparam int dtSpr = 10;                      // DT slave present bit

   logic    sel;                                   // Unit match
   logic    slaveMatch;
   logic    fcSel, tcSel;
   logic    wrMr;
   regWordT mrWord;
   regWordT asWord;

   assign sel        = (unit == unitNum);
   assign slaveMatch = (tcWord[tcSsLsb +: 3] == slaveAddr);

   ////////////////////////////////////////
   // Write strobes

   assign fcSel = write & sel & (regSel == regFc);
   assign tcSel = write & sel & (regSel == regTc);

   assign wrFc = fcSel & dryState;                 // FC, TC locked while busy
   assign wrTc = tcSel & dryState;
   assign wrMr = write & sel & (regSel == regMr);  // MR always writable
   assign wrAs = write & sel & (regSel == regAs) & dataIn[unitNum];

   assign setRmr  = (fcSel | tcSel) & ~dryState;   // Refused modify
   assign setCpar = pat & (wrFc | wrTc | wrMr);
   assign setIlr  = (read | write) & sel & (regSel > regTc);

   assign regAck = sel & (regSel <= regTc);

   // Maintenance register, plain storage
   always_ff @(posedge clk)
   begin
      if (rst)
         mrWord <= '0;
      else if (wrMr)
         mrWord <= dataIn;
   end

   // Our attention bit at position unitNum
   always_comb
   begin
      asWord          = '0;
      asWord[unitNum] = statusWord[dsAta];
   end

   ////////////////////////////////////////
   // Read-back

   always_comb
   begin
      case (regSel)
         regDs:
         begin
            regDat = statusWord;
            if (!slaveMatch)
               regDat[dsMol] = 1'b0;               // Other slaves look off-line
         end
         regEr: regDat = errWord;
         regMr: regDat = mrWord;
         regAs: regDat = asWord;
         regFc: regDat = fcWord;
         regDt:
         begin
            regDat = driveType;
            if (!slaveMatch)
               regDat[dtSpr] = 1'b0;               // Slave not present
         end
         regSn: regDat = slaveMatch ? serialNum : '0;
         regTc: regDat = tcWord;
         regCs1, regCc: regDat = '0;               // No check character
         default: regDat = '0;                     // Illegal address
      endcase
   end

endmodule

/* logic/funcCheck.sv */
// Function decode and GO checks
// Qualifies GO, flags illegal, non-executable and format errors at GO,
// unsafe one cycle later, and issues start for functions that pass

module funcCheck
#(
   parameter logic [2:0] unitNum = 3'd0
)
(
   input  logic             clk,
   input  logic             rst,
   input  logic             go,
   input  logic [2:0]       unit,
   input  logic             pat,
   input  tapePkg::funCodeT fun,
   input  tapePkg::regWordT tcWord,
   input  tapePkg::regWordT fcWord,
   input  logic             bot,
   input  logic             mol,
   input  logic             wrl,
   output logic             setIlf,
   output logic             setNef,
   output logic             setFmte,
   output logic             setUns,
   output logic             start,                 // One cycle after GO
   output tapePkg::funCodeT startFun,
   output logic             drvClr,
   output logic             preset,
   output logic             clrAta
);
   import tapePkg::*;

   logic       goOk;                               // Qualified GO
   logic [3:0] fmt;
   logic       nrzi;
   logic       xferFun, revFun, wrtFun, cntFun;
   logic       ilfCond, nefCond, fmteCond;
   logic       goDly;
   funCodeT    funDly;

   assign goOk = go & (unit == unitNum) & ~pat;   // Bad parity drops GO
   assign fmt  = tcWord[tcFmtLsb +: 4];
   assign nrzi = (tcWord[tcDenLsb +: 3] != den1600);

   ////////////////////////////////////////
   // Function classes

   assign xferFun = (fun == funWrFwd) | (fun == funRdFwd) | (fun == funRdRev) |
                    (fun == funWrChkFwd) | (fun == funWrChkRev);
   assign revFun  = (fun == funSpcRev) | (fun == funRdRev) | (fun == funWrChkRev);
   assign wrtFun  = (fun == funWrFwd) | (fun == funErase) | (fun == funWrTm);
   assign cntFun  = (fun == funSpcFwd) | (fun == funSpcRev) | (fun == funWrFwd);

   ////////////////////////////////////////
   // Checks

   assign ilfCond  = funIllegal[fun];
   assign fmteCond = xferFun & ~fmtLegal[fmt];

   // Non-executable cases
   assign nefCond = (wrtFun & wrl) |               // Write locked
                    (revFun & bot) |               // Nothing behind BOT
                    (cntFun & (fcWord == '0)) |    // Zero count
                    (xferFun & nrzi & (fcWord > nrziMinFc)); // NRZI short

   assign setIlf  = goOk & ilfCond;
   assign setNef  = goOk & nefCond;
   assign setFmte = goOk & fmteCond;

   assign drvClr = goOk & (fun == funDrvClr);
   assign preset = goOk & (fun == funPreset);
   assign clrAta = goOk & ~ilfCond & ~nefCond & ~fmteCond;

   // MOL sampled a cycle late so preset can settle slave select
   assign setUns = goDly & ~mol & (funDly != funDrvClr);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         goDly <= 1'b0;
         start <= 1'b0;
      end
      else
      begin
         goDly <= goOk;
         start <= clrAta & ~drvClr & ~preset;      // Done in GO cycle
      end
      funDly   <= fun;                             // Function of the GO cycle
      startFun <= fun;
   end

endmodule

/* logic/motionCtrl.sv */
// Tape motion control
// Tape control and frame count registers, tape position, attention and
// the space sequencer, plus the drive status word of the selected slave

module motionCtrl
(
   input  logic             clk,
   input  logic             rst,
   input  tapePkg::regWordT dataIn,
   input  logic             wrFc,
   input  logic             wrTc,
   input  logic             wrAs,                  // Clears our attention
   input  logic             clrAta,
   input  logic             start,
   input  tapePkg::funCodeT startFun,
   input  logic             drvClr,
   input  logic             preset,
   input  tapePkg::regWordT errWord,
   input  logic [7:0]       mediumOnline,
   input  logic [7:0]       writeLock,
   input  logic [7:0]       drivePresent,
   output tapePkg::regWordT tcWord,
   output tapePkg::regWordT fcWord,
   output logic             bot,
   output logic             mol,
   output logic             wrl,
   output tapePkg::regWordT statusWord,
   output logic             dryState,
   output logic             ata,
   output logic             dpr
);
   import tapePkg::*;

   logic [2:0]  ss;                                // Selected slave
   logic [15:0] posCnt;                            // Frames from BOT
   logic [15:0] posNext;
   logic        pip;                               // Positioning in progress
   logic        revDir;
   logic        isSpace;
   logic        stopNow;
   regWordT     fcNext;
   regWordT     errPrev;                           // For new error detect

   assign ss  = tcWord[tcSsLsb +: 3];
   assign mol = mediumOnline[ss];
   assign wrl = writeLock[ss];
   assign dpr = drivePresent[ss];
   assign bot = (posCnt == '0);

   assign isSpace = (startFun == funSpcFwd) | (startFun == funSpcRev);
   assign fcNext  = fcWord - 1'b1;
   assign posNext = revDir ? posCnt - 1'b1 : posCnt + 1'b1;
   assign stopNow = (fcNext == '0) | (revDir & (posNext == '0)); // Count or BOT

   // Tape control register
   always_ff @(posedge clk)
   begin
      if (rst || preset)
         tcWord <= '0;
      else if (wrTc)
         tcWord <= dataIn;
   end

   ////////////////////////////////////////
   // Space sequencer

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         fcWord   <= '0;
         posCnt   <= '0;
         pip      <= 1'b0;
         dryState <= 1'b1;
         revDir   <= 1'b0;
      end
      else if (drvClr)
      begin
         pip      <= 1'b0;                         // Abort motion
         dryState <= 1'b1;
      end
      else if (pip)
      begin
         fcWord <= fcNext;                         // One frame per cycle
         posCnt <= posNext;
         if (stopNow)
         begin
            pip      <= 1'b0;
            dryState <= 1'b1;
         end
      end
      else if (start && isSpace)
      begin
         pip      <= 1'b1;
         dryState <= 1'b0;
         revDir   <= (startFun == funSpcRev);
      end
      else if (wrFc)
         fcWord <= dataIn;
   end

   ////////////////////////////////////////
   // Attention

   always_ff @(posedge clk)
   begin
      if (rst)
         errPrev <= '0;
      else
         errPrev <= errWord;
   end

   always_ff @(posedge clk)
   begin
      if (rst || drvClr)
         ata <= 1'b0;
      else if ((|(errWord & ~errPrev)) || (pip && stopNow) || (start && !isSpace))
         ata <= 1'b1;                              // Error, end of space or transfer
      else if (clrAta || wrAs)
         ata <= 1'b0;
   end

   always_comb
   begin
      statusWord        = '0;
      statusWord[dsAta] = ata;
      statusWord[dsErr] = |errWord;
      statusWord[dsPip] = pip;
      statusWord[dsMol] = mol;
      statusWord[dsWrl] = wrl;
      statusWord[dsDpr] = dpr;
      statusWord[dsDry] = dryState;
      statusWord[dsBot] = bot;
   end

endmodule

/* logic/tapeFormatter.sv */
// Tape formatter top level
// Massbus register front end of a TM03 style formatter with TU77 slaves

module tapeFormatter
#(
   parameter logic [2:0]  unitNum   = 3'd0,        // Massbus unit
   parameter logic [15:0] driveType = 16'o142054,  // TM03 with TU77
   parameter logic [15:0] serialNum = 16'o000017,
   parameter logic [2:0]  slaveAddr = 3'd0         // Slave that answers SN
)
(
   input  logic             clk,
   input  logic             rst,
   input  logic [2:0]       unit,
   input  tapePkg::regAddrT regSel,
   input  logic             read,
   input  logic             write,
   input  tapePkg::regWordT dataIn,
   input  logic             pat,                   // Parity test
   input  logic             go,                    // Single cycle GO
   input  tapePkg::funCodeT fun,
   input  logic [7:0]       mediumOnline,          // Console, per slave
   input  logic [7:0]       writeLock,
   input  logic [7:0]       drivePresent,
   output tapePkg::regWordT regDat,
   output logic             regAck,
   output logic             ata,
   output logic             dry,
   output logic             dpr
);
   import tapePkg::*;

   regWordT tcWord;
   regWordT fcWord;
   regWordT errWord;
   regWordT statusWord;
   funCodeT startFun;
   logic    bot, mol, wrl;
   logic    wrFc, wrTc, wrAs;
   logic    setIlr, setRmr, setCpar;              // Register side errors
   logic    setIlf, setNef, setFmte, setUns;      // GO side errors
   logic    start, drvClr, preset, clrAta;

   regDecode #(
      .unitNum   (unitNum),
      .driveType (driveType),
      .serialNum (serialNum),
      .slaveAddr (slaveAddr)
   ) regDecode_i (
      .clk (clk), .rst (rst), .unit (unit), .regSel (regSel), .read (read),
      .write (write), .pat (pat), .dataIn (dataIn), .dryState (dry),
      .statusWord (statusWord), .errWord (errWord), .fcWord (fcWord),
      .tcWord (tcWord), .wrFc (wrFc), .wrTc (wrTc), .wrAs (wrAs),
      .setIlr (setIlr), .setRmr (setRmr), .setCpar (setCpar),
      .regDat (regDat), .regAck (regAck)
   );

   funcCheck #(.unitNum (unitNum)) funcCheck_i (
      .clk (clk), .rst (rst), .go (go), .unit (unit), .pat (pat), .fun (fun),
      .tcWord (tcWord), .fcWord (fcWord), .bot (bot), .mol (mol), .wrl (wrl),
      .setIlf (setIlf), .setNef (setNef), .setFmte (setFmte), .setUns (setUns),
      .start (start), .startFun (startFun), .drvClr (drvClr), .preset (preset),
      .clrAta (clrAta)
   );

   errorReg errorReg_i (
      .clk (clk), .rst (rst), .drvClr (drvClr), .setIlf (setIlf),
      .setIlr (setIlr), .setRmr (setRmr), .setCpar (setCpar),
      .setFmte (setFmte), .setNef (setNef), .setUns (setUns), .errWord (errWord)
   );

   motionCtrl motionCtrl_i (
      .clk (clk), .rst (rst), .dataIn (dataIn), .wrFc (wrFc), .wrTc (wrTc),
      .wrAs (wrAs), .clrAta (clrAta), .start (start), .startFun (startFun),
      .drvClr (drvClr), .preset (preset), .errWord (errWord),
      .mediumOnline (mediumOnline), .writeLock (writeLock),
      .drivePresent (drivePresent), .tcWord (tcWord), .fcWord (fcWord),
      .bot (bot), .mol (mol), .wrl (wrl), .statusWord (statusWord),
      .dryState (dry), .ata (ata), .dpr (dpr)
   );

endmodule

/* bench/tapeFormatterTb.sv */
// Tape formatter testbench
// Drives the Massbus register and GO ports through register read-back,
// error, space and attention sequences, checked by concurrent assertions

module tapeFormatterTb;
   import tapePkg::*;

   localparam int          clkPeriod    = 40;
   localparam int          resetCycles  = 16;
   localparam int          numTests     = 6;
   localparam int          watchdogTime = numTests * 2000 + resetCycles * clkPeriod;
   localparam int          waitLimit    = 64;      // Cycles before a wait gives up
   localparam logic [2:0]  tbUnit       = 3'd2;
   localparam logic [15:0] tbDriveType  = 16'o142054;
   localparam logic [15:0] tbSerial     = 16'o004321;
   localparam logic [2:0]  tbSlave      = 3'd1;

   // Expected error register bits
   localparam regWordT ilfBit  = 16'h0001;
   localparam regWordT ilrBit  = 16'h0002;
   localparam regWordT rmrBit  = 16'h0004;
   localparam regWordT cparBit = 16'h0008;
   localparam regWordT fmteBit = 16'h0010;
   localparam regWordT nefBit  = 16'h0040;
   localparam regWordT unsBit  = 16'h4000;
   localparam regWordT dtPresent = 16'h0400;      // DT slave present
   localparam regWordT dsAtBot   = 16'h9182;      // ATA MOL DPR DRY BOT

   localparam funCodeT illegalFuns [18] = '{5'o02, 5'o05, 5'o06, 5'o07, 5'o11, 5'o16,
      5'o17, 5'o20, 5'o21, 5'o22, 5'o23, 5'o25, 5'o26, 5'o31, 5'o32, 5'o33, 5'o35, 5'o36};

   logic       clk = 1'b0;
   logic       rst, read, write, pat, go;
   logic [2:0] unit;
   regAddrT    regSel;
   regWordT    dataIn;
   funCodeT    fun;
   logic [7:0] mediumOnline, writeLock, drivePresent;
   regWordT    regDat;
   logic       regAck, ata, dry, dpr;

   // Checker flags, driven by the tasks
   logic    rdChk = 1'b0;
   logic    nakChk = 1'b0;
   logic    ataChk = 1'b0;
   logic    dprChk = 1'b0;
   logic    runChk = 1'b0;
   regWordT rdExp = '0;
   logic    ataExp = 1'b0;
   logic    dprExp = 1'b0;
   int      runExp = 0;
   int      runLen = 0;                            // Current busy run
   int      lastRun = 0;                           // Length of last busy run
   int      errCount = 0;
   int      errMark = 0;
   int      passCount = 0;
   int      failCount = 0;

   tapeFormatter #(
      .unitNum   (tbUnit),
      .driveType (tbDriveType),
      .serialNum (tbSerial),
      .slaveAddr (tbSlave)
   ) tapeFormatter_i (
      .clk (clk), .rst (rst), .unit (unit), .regSel (regSel), .read (read),
      .write (write), .dataIn (dataIn), .pat (pat), .go (go), .fun (fun),
      .mediumOnline (mediumOnline), .writeLock (writeLock),
      .drivePresent (drivePresent), .regDat (regDat), .regAck (regAck),
      .ata (ata), .dry (dry), .dpr (dpr)
   );

   always #(clkPeriod / 2) clk = ~clk;

   // Busy run length, counted on the falling edge
   always @(negedge clk)
   begin
      if (dry === 1'b0)
         runLen <= runLen + 1;
      else if (runLen != 0)
      begin
         lastRun <= runLen;
         runLen  <= 0;
      end
   end

   ////////////////////////////////////////
   // Assertions

   readCheck: assert property (@(posedge clk) rdChk |-> regAck && (regDat == rdExp))
   else
   begin
      errCount = errCount + 1;
      $display("ERROR %0t: register %0o read %h, expected %h", $time, $sampled(regSel),
               $sampled(regDat), rdExp);
   end

   nakCheck: assert property (@(posedge clk) nakChk |-> !regAck)
   else
   begin
      errCount = errCount + 1;
      $display("ERROR %0t: register %0o acknowledged", $time, $sampled(regSel));
   end

   ataCheck: assert property (@(posedge clk) ataChk |-> (ata == ataExp))
   else
   begin
      errCount = errCount + 1;
      $display("ERROR %0t: ata is %0b, expected %0b", $time, $sampled(ata), ataExp);
   end

   dprCheck: assert property (@(posedge clk) dprChk |-> (dpr == dprExp))
   else
   begin
      errCount = errCount + 1;
      $display("ERROR %0t: dpr is %0b, expected %0b", $time, $sampled(dpr), dprExp);
   end

   runCheck: assert property (@(posedge clk) runChk |-> (lastRun == runExp))
   else
   begin
      errCount = errCount + 1;
      $display("ERROR %0t: dry low %0d cycles, expected %0d", $time, lastRun, runExp);
   end

   ////////////////////////////////////////
   // Bus tasks

   task automatic writeReg(input regAddrT addr, input regWordT data, input logic parity);
      @(posedge clk);
      regSel <= addr;
      dataIn <= data;
      pat    <= parity;
      write  <= 1'b1;
      @(posedge clk);
      write <= 1'b0;
      pat   <= 1'b0;
   endtask

   task automatic readReg(input regAddrT addr, input regWordT expected);
      @(posedge clk);
      regSel <= addr;
      read   <= 1'b1;
      rdExp  <= expected;
      rdChk  <= 1'b1;                              // Checked at the next edge
      @(posedge clk);
      read  <= 1'b0;
      rdChk <= 1'b0;
   endtask

   // Select only, no read strobe, so no ilr
   task automatic probeNoAck(input regAddrT addr);
      @(posedge clk);
      regSel <= addr;
      nakChk <= 1'b1;
      @(posedge clk);
      nakChk <= 1'b0;
   endtask

   task automatic issueGo(input funCodeT f);
      @(posedge clk);
      fun <= f;
      go  <= 1'b1;
      @(posedge clk);
      go <= 1'b0;
   endtask

   // Waits on ata or dry, sampled mid-cycle
   task automatic waitSignal(input bit useAta, input logic level);
      int n;
      n = 0;
      @(negedge clk);
      while (((useAta ? ata : dry) !== level) && (n < waitLimit))
      begin
         n++;
         @(negedge clk);
      end
      if ((useAta ? ata : dry) !== level)
      begin
         errCount = errCount + 1;
         $display("Timeout at %0t: %s never reached %0b", $time, useAta ? "ata" : "dry",
                  level);
      end
   endtask

   task automatic expectAta(input logic level);
      @(posedge clk);
      ataExp <= level;
      ataChk <= 1'b1;
      @(posedge clk);
      ataChk <= 1'b0;
   endtask

   task automatic expectDpr(input logic level);
      @(posedge clk);
      dprExp <= level;
      dprChk <= 1'b1;
      @(posedge clk);
      dprChk <= 1'b0;
   endtask

   task automatic checkRun(input int cycles);
      @(posedge clk);
      runExp <= cycles;
      runChk <= 1'b1;
      @(posedge clk);
      runChk <= 1'b0;
   endtask

   function automatic regWordT makeTc(input logic [2:0] ss, input logic [3:0] fmt,
                                      input logic [2:0] den);
      return {5'd0, den, fmt, 1'b0, ss};           // DEN FMT - SS
   endfunction

   // Waits out pending assertion actions first
   task automatic finishTest(input string name);
      @(posedge clk);
      if (errCount == errMark)
      begin
         passCount++;
         $display("%s: pass", name);
      end
      else
      begin
         failCount++;
         $display("%s: FAIL with %0d errors", name, errCount - errMark);
      end
      errMark = errCount;
   endtask

   ////////////////////////////////////////
   // Stimulus

   initial
   begin
      int         n;
      int         m;
      int         pos;                             // Expected frames from BOT
      regWordT    rnd;
      logic [3:0] badFmt;

      void'($urandom(32'haa1a_9d17));
      rst          <= 1'b1;
      unit         <= tbUnit;
      regSel       <= regCs1;
      read         <= 1'b0;
      write        <= 1'b0;
      dataIn       <= '0;
      pat          <= 1'b0;
      go           <= 1'b0;
      fun          <= '0;
      mediumOnline <= 8'hFF;                       // All slaves on-line
      writeLock    <= 8'h00;
      drivePresent <= 8'hFF;
      repeat (resetCycles) @(posedge clk);
      rst <= 1'b0;

      // Read-back, DT and SN per slave, no ack above TC
      rnd = 16'($urandom);
      writeReg(regTc, rnd, 1'b0);
      readReg(regTc, rnd);
      rnd = 16'($urandom);
      writeReg(regFc, rnd, 1'b0);
      readReg(regFc, rnd);
      writeReg(regTc, makeTc(tbSlave, 4'd0, 3'd4), 1'b0);
      readReg(regDt, tbDriveType);
      readReg(regSn, tbSerial);
      writeReg(regTc, makeTc(tbSlave + 3'd1, 4'd0, 3'd4), 1'b0);
      readReg(regDt, tbDriveType & ~dtPresent);
      readReg(regSn, 16'd0);
      probeNoAck(5'o12);
      probeNoAck(5'(10 + $urandom % 22));
      probeNoAck(5'o37);
      finishTest("register read-back");

      writeReg(5'o14, 16'($urandom), 1'b0);        // Above TC
      readReg(regEr, ilrBit);
      writeReg(regFc, 16'($urandom), 1'b1);
      readReg(regEr, ilrBit | cparBit);
      issueGo(funDrvClr);
      readReg(regEr, 16'd0);
      expectAta(1'b0);
      finishTest("register errors");

      // ILF, FMTE, NEF, each with attention
      writeReg(regTc, makeTc(tbSlave, 4'd0, 3'd4), 1'b0);
      n = int'($urandom % 18);
      issueGo(illegalFuns[n]);
      readReg(regEr, ilfBit);
      waitSignal(1'b1, 1'b1);
      issueGo(funDrvClr);
      do
         badFmt = 4'($urandom);
      while (badFmt == 4'd0 || badFmt == 4'd3 || badFmt == 4'd12 || badFmt == 4'd14);
      writeReg(regTc, makeTc(tbSlave, badFmt, 3'd4), 1'b0);
      issueGo(funRdFwd);
      readReg(regEr, fmteBit);
      waitSignal(1'b1, 1'b1);
      issueGo(funDrvClr);
      writeReg(regTc, makeTc(tbSlave, 4'd0, 3'd4), 1'b0);
      writeReg(regFc, 16'd100, 1'b0);
      @(posedge clk);
      writeLock <= 8'd1 << tbSlave;
      issueGo(funWrFwd);
      readReg(regEr, nefBit);
      waitSignal(1'b1, 1'b1);
      issueGo(funDrvClr);
      writeLock <= 8'h00;
      finishTest("function checks");

      n = 4 + int'($urandom % 5);
      writeReg(regFc, 16'(n), 1'b0);
      issueGo(funSpcFwd);
      waitSignal(1'b0, 1'b0);
      writeReg(regFc, 16'($urandom), 1'b0);        // Refused, still busy
      waitSignal(1'b0, 1'b1);
      checkRun(n);
      expectAta(1'b1);
      readReg(regFc, 16'd0);
      readReg(regEr, rmrBit);
      issueGo(funDrvClr);
      pos = n;
      finishTest("space forward");

      m = 3 + int'($urandom % 4);
      writeReg(regFc, 16'(m), 1'b0);
      issueGo(funSpcFwd);
      waitSignal(1'b0, 1'b0);
      waitSignal(1'b0, 1'b1);
      checkRun(m);
      expectAta(1'b1);                             // Count reached zero
      pos = pos + m;
      writeReg(regFc, 16'(pos + 5), 1'b0);         // Five past BOT
      issueGo(funSpcRev);
      waitSignal(1'b0, 1'b0);
      expectAta(1'b0);                             // Cleared by the GO
      waitSignal(1'b0, 1'b1);
      checkRun(pos);
      expectAta(1'b1);
      readReg(regFc, 16'd5);
      readReg(regDs, dsAtBot);
      issueGo(funDrvClr);
      issueGo(funSpcRev);                          // Reverse at BOT
      readReg(regEr, nefBit);
      waitSignal(1'b1, 1'b1);
      issueGo(funDrvClr);
      finishTest("space reverse");

      @(posedge clk);
      mediumOnline <= ~(8'd1 << tbSlave);
      issueGo(funRdFwd);
      readReg(regEr, unsBit);
      waitSignal(1'b1, 1'b1);
      readReg(regAs, 16'd1 << tbUnit);
      writeReg(regAs, 16'd1 << tbUnit, 1'b0);
      expectAta(1'b0);
      readReg(regAs, 16'd0);
      drivePresent <= ~(8'd1 << tbSlave);          // Selected slave gone
      expectDpr(1'b0);
      drivePresent <= 8'hFF;
      expectDpr(1'b1);
      issueGo(funDrvClr);
      mediumOnline <= 8'hFF;
      finishTest("unsafe and attention");

      $display("Tests %0d, passed %0d, failed %0d, errors %0d", numTests, passCount,
               failCount, errCount);
      if (errCount == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(watchdogTime);
      $display("Timeout: the run did not finish within %0d time units", watchdogTime);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* tapeFormatter.f */
logic/tapePkg.sv
logic/errorReg.sv
logic/regDecode.sv
logic/funcCheck.sv
logic/motionCtrl.sv
logic/tapeFormatter.sv
bench/tapeFormatterTb.sv

/* run.sh */
#!/bin/sh
# Build the tape formatter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tapeFormatterTb -f tapeFormatter.f

./obj_dir/VtapeFormatterTb | tee sim.log

# Verdict from the log
if grep -q "CHECKS FAILED" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"
